// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the receiver testbench with Verilator and runs it
set -eo pipefail

cd "$(dirname "$0")"

log=sim.log

rm -rf obj_dir
verilator --binary --timing --assert \
    --top-module tb_uart_rx \
    -f tb.f \
    -o tb_uart_rx_sim

./obj_dir/tb_uart_rx_sim | tee "$log"

if grep -q "Test failed" "$log"; then
    echo "simulation failed, see $log"
    exit 1
fi

echo "simulation passed"

// ==== tb.f ====
verilog/uart_rx_pkg.sv
verilog/uart_rx_serial.sv
verilog/rx_word_ram.sv
verilog/uart_rx_mmio.sv
verilog/uart_rx_top.sv
tests/uart_rx_assert.sv
tests/tb_uart_rx.sv

// ==== tests/tb_uart_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_uart_rx;

    localparam int cpb          = uart_rx_pkg::clks_per_bit;
    // ten bits on the line plus two idle bit times
    localparam int frame_cycles = 12 * cpb;
    // start edge to byte strobe: two sync flops, start detect, 9.5 bits
    localparam int pulse_cycle  = 9 * cpb + cpb / 2 + 3;
    // about 1100 frames plus the host reads
    localparam int max_cycles   = 1100 * frame_cycles + 68_000;

    logic                   clk = 1'b0;
    logic                   arst_n;
    logic                   rx_line;
    logic                   cmd_start;
    logic                   cmd_ready;
    uart_rx_pkg::bus_addr_t addr;
    uart_rx_pkg::word_t     rdata;
    logic                   rdata_valid;

    // reference model of the ring
    uart_rx_pkg::byte_t model_mem [1024];
    logic               model_known [1024];
    uart_rx_pkg::tail_t model_tail;
    uart_rx_pkg::word_t model_wrap;

    // read handed to the compare process
    logic                   chk_busy;
    int                     chk_age;
    uart_rx_pkg::bus_addr_t chk_addr;
    uart_rx_pkg::word_t     chk_exp;
    uart_rx_pkg::word_t     chk_mask;

    int n_checks;
    int n_errors;
    int cycles;
    int seed;

    always #50 clk = ~clk;

    uart_rx_top dut0 (
        .clk         (clk),
        .arst_n      (arst_n),
        .rx_line     (rx_line),
        .cmd_start   (cmd_start),
        .cmd_ready   (cmd_ready),
        .addr        (addr),
        .rdata       (rdata),
        .rdata_valid (rdata_valid)
    );

    // little-endian packing of the model, or a register value
    function automatic uart_rx_pkg::word_t expected_word(input uart_rx_pkg::bus_addr_t a);
        int base;
        base = int'(a[9:2]) * 4;
        if (a == uart_rx_pkg::tail_offset) begin
            return uart_rx_pkg::word_t'(model_tail);
        end
        if (a == uart_rx_pkg::count_offset) begin
            return model_wrap;
        end
        return {model_mem[base + 3], model_mem[base + 2], model_mem[base + 1], model_mem[base]};
    endfunction

    // lanes never written hold whatever the ram powered up with
    function automatic uart_rx_pkg::word_t known_mask(input uart_rx_pkg::bus_addr_t a);
        uart_rx_pkg::word_t m;
        int                 base;
        int                 i;
        m = '0;
        base = int'(a[9:2]) * 4;
        if (a == uart_rx_pkg::tail_offset || a == uart_rx_pkg::count_offset) begin
            return '1;
        end
        for (i = 0; i < 4; i++) begin
            if (model_known[base + i]) begin
                m[8 * i +: 8] = 8'hff;
            end
        end
        return m;
    endfunction

    function automatic void store_byte(input uart_rx_pkg::byte_t b);
        model_mem[model_tail]   = b;
        model_known[model_tail] = 1'b1;
        if (model_tail == uart_rx_pkg::tail_last) begin
            model_wrap = model_wrap + 1'b1;
        end
        model_tail = model_tail + 1'b1;
    endfunction

    // start bit, data lsb first, stop bit, then two idle bit times
    task automatic send_frame(input uart_rx_pkg::byte_t b, input logic stop_bit);
        logic [9:0] bits;
        int         i;
        bits = {stop_bit, b, 1'b0};
        @(posedge clk);
        for (i = 0; i < 10; i++) begin
            rx_line <= bits[i];
            repeat (cpb) @(posedge clk);
        end
        rx_line <= 1'b1;
        repeat (2 * cpb) @(posedge clk);
    endtask

    task automatic host_read(input uart_rx_pkg::bus_addr_t a, input uart_rx_pkg::word_t exp,
                             input uart_rx_pkg::word_t mask);
        @(negedge clk);
        while (!cmd_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        cmd_start <= 1'b1;
        addr      <= a;
        chk_addr = a;
        chk_exp  = exp;
        chk_mask = mask;
        chk_age  = 0;
        chk_busy = 1'b1;
        @(posedge clk);
        cmd_start <= 1'b0;
        // addr stays put until the sample is taken
        while (chk_busy) begin
            @(posedge clk);
        end
    endtask

    task automatic check_word(input uart_rx_pkg::bus_addr_t a);
        host_read(a, expected_word(a), known_mask(a));
    endtask

    // first cycle at least 3 after cmd_start with rdata_valid high
    always @(negedge clk) begin
        if (chk_busy) begin
            if (chk_age >= 3 && rdata_valid) begin
                n_checks = n_checks + 1;
                if (((rdata ^ chk_exp) & chk_mask) !== '0) begin
                    n_errors = n_errors + 1;
                    $display("Mismatch at %0t ns: addr 0x%08h read 0x%08h, expected 0x%08h",
                             $time, chk_addr, rdata, chk_exp);
                end
                chk_busy = 1'b0;
            end
            chk_age = chk_age + 1;
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: the tests did not finish within %0d cycles", max_cycles);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        int                     i;
        int                     errs_before;
        int                     cmd_cycle [6];
        uart_rx_pkg::byte_t     b;
        uart_rx_pkg::bus_addr_t a;
        uart_rx_pkg::word_t     old_word;
        uart_rx_pkg::word_t     old_mask;
        uart_rx_pkg::word_t     new_word;
        uart_rx_pkg::word_t     new_mask;
        seed      = 77342;
        arst_n    <= 1'b0;
        rx_line   <= 1'b1;
        cmd_start <= 1'b0;
        addr      <= '0;
        chk_busy  = 1'b0;
        chk_age   = 0;
        chk_addr  = '0;
        chk_exp   = '0;
        chk_mask  = '0;
        n_checks  = 0;
        n_errors  = 0;
        cycles    = 0;
        model_tail = '0;
        model_wrap = '0;
        for (i = 0; i < 1024; i++) begin
            model_mem[i]   = '0;
            model_known[i] = 1'b0;
        end
        // cmd_start cycles around the strobe at pulse_cycle
        cmd_cycle = '{90, 97, 98, 101, 102, 103};
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;

        errs_before = n_errors;
        @(negedge clk);
        n_checks = n_checks + 1;
        if (!cmd_ready) begin
            n_errors = n_errors + 1;
            $display("cmd_ready is low right after reset at %0t ns", $time);
        end
        host_read(uart_rx_pkg::tail_offset, 32'd0, '1);
        host_read(uart_rx_pkg::count_offset, 32'd0, '1);
        $display("test 1 reset state: %0d errors", n_errors - errs_before);

        errs_before = n_errors;
        for (i = 0; i < 37; i++) begin
            b = uart_rx_pkg::byte_t'($random(seed));
            store_byte(b);
            send_frame(b, 1'b1);
        end
        for (i = 0; i < 10; i++) begin
            check_word(uart_rx_pkg::bus_addr_t'(i * 4));
        end
        host_read(uart_rx_pkg::tail_offset, 32'd37, '1);
        $display("test 2 packing: %0d errors", n_errors - errs_before);

        errs_before = n_errors;
        while (int'(model_tail) + 1024 * int'(model_wrap) < 1030) begin
            b = uart_rx_pkg::byte_t'($random(seed));
            store_byte(b);
            send_frame(b, 1'b1);
        end
        host_read(uart_rx_pkg::count_offset, 32'd1, '1);
        host_read(uart_rx_pkg::tail_offset, 32'd6, '1);
        check_word(32'd0);
        check_word(32'd4);
        check_word(32'd8);
        $display("test 3 wrap-around: %0d errors", n_errors - errs_before);

        // every lane now holds a known byte, so old and new words differ
        errs_before = n_errors;
        for (i = 0; i < 6; i++) begin
            b = uart_rx_pkg::byte_t'($random(seed));
            a = uart_rx_pkg::bus_addr_t'({model_tail[9:2], 2'b00});
            old_word = expected_word(a);
            old_mask = known_mask(a);
            store_byte(b);
            new_word = expected_word(a);
            new_mask = known_mask(a);
            fork
                send_frame(b, 1'b1);
                begin
                    repeat (cmd_cycle[i]) @(posedge clk);
                    // a command no later than the strobe gets the word before the merge
                    if (cmd_cycle[i] <= pulse_cycle) begin
                        host_read(a, old_word, old_mask);
                    end else begin
                        host_read(a, new_word, new_mask);
                    end
                end
            join
        end
        check_word(uart_rx_pkg::tail_offset);
        $display("test 4 reads during reception: %0d errors", n_errors - errs_before);

        errs_before = n_errors;
        b = uart_rx_pkg::byte_t'($random(seed));
        send_frame(b, 1'b0);
        check_word(uart_rx_pkg::tail_offset);
        for (i = 0; i <= int'(model_tail[9:2]); i++) begin
            check_word(uart_rx_pkg::bus_addr_t'(i * 4));
        end
        b = uart_rx_pkg::byte_t'($random(seed));
        a = uart_rx_pkg::bus_addr_t'({model_tail[9:2], 2'b00});
        store_byte(b);
        send_frame(b, 1'b1);
        check_word(a);
        check_word(uart_rx_pkg::tail_offset);
        $display("test 5 framing error: %0d errors", n_errors - errs_before);

        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/uart_rx_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_rx_assert (
    input wire                             clk,
    input wire                             arst_n,
    input wire uart_rx_pkg::rx_buf_state_t state,
    input wire                             rx_valid,
    input wire uart_rx_pkg::tail_t         tail,
    input wire                             cmd_ready
);

    // frames are spaced so a pulse never meets the busy states
    rx_in_busy: assert property (@(posedge clk) disable iff (!arst_n)
        !(rx_valid && (state == uart_rx_pkg::write_mem ||
                       state == uart_rx_pkg::readbuf_before_write)))
        else $error("rx_valid arrived while the buffer controller was busy");

    // one byte per write_mem, rollover included
    tail_step: assert property (@(posedge clk) disable iff (!arst_n)
        tail == $past(tail) || tail == uart_rx_pkg::tail_t'($past(tail) + 1'b1))
        else $error("tail moved by more than one in a cycle");

    ready_idle: assert property (@(posedge clk) disable iff (!arst_n)
        cmd_ready == (state == uart_rx_pkg::idle))
        else $error("cmd_ready does not match the idle state");

endmodule

bind uart_rx_mmio uart_rx_assert u_assert (
    .clk       (clk),
    .arst_n    (arst_n),
    .state     (state),
    .rx_valid  (rx_valid),
    .tail      (tail),
    .cmd_ready (cmd_ready)
);

`default_nettype wire

// ==== verilog/rx_word_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_word_ram (
    input  wire                          clk,
    input  wire uart_rx_pkg::word_addr_t rd_addr,
    output uart_rx_pkg::word_t           rd_data,
    input  wire                          wr_en,
    input  wire uart_rx_pkg::word_addr_t wr_addr,
    input  wire uart_rx_pkg::word_t      wr_data
);

    uart_rx_pkg::word_t mem [uart_rx_pkg::buf_words];

    // read returns the old word when both ports hit the same address
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// ==== verilog/uart_rx_mmio.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_rx_mmio (
    input  wire                         clk,
    input  wire                         arst_n,
    input  wire uart_rx_pkg::byte_t     rx_byte,
    input  wire                         rx_valid,
    input  wire                         cmd_start,
    output logic                        cmd_ready,
    input  wire uart_rx_pkg::bus_addr_t addr,
    output uart_rx_pkg::word_t          rdata,
    output logic                        rdata_valid
);

    uart_rx_pkg::rx_buf_state_t state;

    // ring position and rollover count
    uart_rx_pkg::tail_t tail;
    uart_rx_pkg::word_t wrap_count;

    // byte waiting for its read-modify-write
    uart_rx_pkg::byte_t rx_hold;

    logic start_pend;
    logic rd_host;
    logic rd_host_q;

    uart_rx_pkg::word_addr_t rd_addr;
    uart_rx_pkg::word_addr_t wr_addr;
    uart_rx_pkg::word_t      ram_rdata;
    uart_rx_pkg::word_t      merged;
    logic                    ram_we;

    logic is_tail;
    logic is_count;
    logic is_buffer;

    // address decode
    assign is_tail   = (addr == uart_rx_pkg::tail_offset);
    assign is_count  = (addr == uart_rx_pkg::count_offset);
    assign is_buffer = !is_tail && !is_count;

    // one read port, shared by the host and the merge
    always_comb begin
        case (state)
            uart_rx_pkg::idle: begin
                // a fresh byte takes the port first
                rd_host = !rx_valid;
            end
            uart_rx_pkg::readbuf_before_write: begin
                rd_host = 1'b0;
            end
            default: begin
                rd_host = 1'b1;
            end
        endcase
    end

    assign rd_addr = rd_host ? addr[9:2] : tail[9:2];
    assign wr_addr = tail[9:2];
    assign ram_we  = (state == uart_rx_pkg::write_mem);

    // little-endian lane select from the low tail bits
    always_comb begin
        merged = ram_rdata;
        case (tail[1:0])
            2'd0: merged[7:0]   = rx_hold;
            2'd1: merged[15:8]  = rx_hold;
            2'd2: merged[23:16] = rx_hold;
            2'd3: merged[31:24] = rx_hold;
            default: merged = ram_rdata;
        endcase
    end

    rx_word_ram u_ram (
        .clk     (clk),
        .rd_addr (rd_addr),
        .rd_data (ram_rdata),
        .wr_en   (ram_we),
        .wr_addr (wr_addr),
        .wr_data (merged)
    );

    assign cmd_ready = (state == uart_rx_pkg::idle);

    // registers are always readable, buffer words only when the port is free
    assign rdata_valid = is_tail || is_count ||
                         (is_buffer && (state == uart_rx_pkg::idle ||
                                        state == uart_rx_pkg::readbuf_before_write));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= uart_rx_pkg::idle;
            tail       <= '0;
            wrap_count <= '0;
            start_pend <= 1'b0;
            rd_host_q  <= 1'b0;
        end else begin
            start_pend <= cmd_start;
            rd_host_q  <= rd_host;
            case (state)
                uart_rx_pkg::idle: begin
                    if (rx_valid) begin
                        state <= uart_rx_pkg::write_mem;
                    end else if (cmd_start) begin
                        state <= uart_rx_pkg::readbuf_after_rx;
                    end
                end
                uart_rx_pkg::write_mem: begin
                    tail <= tail + 1'b1;
                    if (tail == uart_rx_pkg::tail_last) begin
                        wrap_count <= wrap_count + 1'b1;
                    end
                    // host command that lost to the byte in idle
                    if (start_pend && is_buffer) begin
                        state <= uart_rx_pkg::readbuf_after_rx;
                    end else begin
                        state <= uart_rx_pkg::idle;
                    end
                end
                uart_rx_pkg::readbuf_after_rx: begin
                    if (rx_valid) begin
                        state <= uart_rx_pkg::readbuf_before_write;
                    end else begin
                        state <= uart_rx_pkg::idle;
                    end
                end
                uart_rx_pkg::readbuf_before_write: begin
                    // host word is out, now the merge may proceed
                    state <= uart_rx_pkg::write_mem;
                end
                default: begin
                    state <= uart_rx_pkg::idle;
                end
            endcase
        end
    end

    // capture the byte in the states that accept a pulse
    always_ff @(posedge clk) begin
        if (rx_valid && (state == uart_rx_pkg::idle ||
                         state == uart_rx_pkg::readbuf_after_rx)) begin
            rx_hold <= rx_byte;
        end
    end

    // ram output only counts when last cycle's read used the host address
    always_ff @(posedge clk) begin
        if (is_tail) begin
            rdata <= uart_rx_pkg::word_t'(tail);
        end else if (is_count) begin
            rdata <= wrap_count;
        end else if (rd_host_q) begin
            rdata <= ram_rdata;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/uart_rx_pkg.sv ====
`default_nettype none

package uart_rx_pkg;

    // received byte and buffer word
    typedef logic [7:0]  byte_t;
    typedef logic [31:0] word_t;

    // 256 words of 4 bytes give a 1 KiB ring
    typedef logic [7:0]  word_addr_t;
    typedef logic [9:0]  tail_t;

    // host side byte address
    typedef logic [31:0] bus_addr_t;

    localparam int buf_words = 256;
    localparam tail_t tail_last = 10'd1023;

    // bit timing
    localparam int clk_freq_hz  = 10_000_000;
    localparam int baud_rate    = 1_000_000;
    localparam int clks_per_bit = clk_freq_hz / baud_rate;
    localparam int bit_cnt_w    = $clog2(clks_per_bit);

    // counts cycles inside one bit time
    typedef logic [bit_cnt_w-1:0] bit_cnt_t;

    // register offsets, anything else hits the buffer
    localparam bus_addr_t tail_offset  = 32'h0000_0400;
    localparam bus_addr_t count_offset = 32'h0000_0404;

    // buffer controller states
    typedef enum logic [1:0] {
        idle,
        write_mem,
        readbuf_after_rx,
        readbuf_before_write
    } rx_buf_state_t;

endpackage

`default_nettype wire

// ==== verilog/uart_rx_serial.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_rx_serial (
    input  wire                clk,
    input  wire                arst_n,
    input  wire                rx_line,
    output uart_rx_pkg::byte_t rx_byte,
    output logic               rx_valid
);

    typedef enum logic [1:0] {
        idle,
        start,
        data,
        stop
    } rx_state_t;

    rx_state_t             state;
    uart_rx_pkg::bit_cnt_t cnt;
    logic [2:0]            bit_idx;
    uart_rx_pkg::byte_t    shift_reg;

    logic line_meta;
    logic line_sync;

    logic half_end;
    logic bit_end;

    // two flops against metastability, line idles high
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            line_meta <= 1'b1;
            line_sync <= 1'b1;
        end else begin
            line_meta <= rx_line;
            line_sync <= line_meta;
        end
    end

    // middle of the start bit, then full bit periods
    assign half_end = (cnt == uart_rx_pkg::bit_cnt_t'(uart_rx_pkg::clks_per_bit / 2 - 1));
    assign bit_end  = (cnt == uart_rx_pkg::bit_cnt_t'(uart_rx_pkg::clks_per_bit - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= idle;
            cnt      <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                idle: begin
                    cnt <= '0;
                    if (!line_sync) begin
                        state <= start;
                    end
                end
                start: begin
                    if (half_end) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        // glitch shorter than half a bit is dropped
                        state   <= line_sync ? idle : data;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                data: begin
                    if (bit_end) begin
                        cnt     <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= stop;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                stop: begin
                    if (bit_end) begin
                        cnt      <= '0;
                        state    <= idle;
                        // framing error when the stop bit is low
                        rx_valid <= line_sync;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // lsb arrives first, shift in from the top
    always_ff @(posedge clk) begin
        if (state == data && bit_end) begin
            shift_reg <= {line_sync, shift_reg[7:1]};
        end
        if (state == stop && bit_end && line_sync) begin
            rx_byte <= shift_reg;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/uart_rx_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_rx_top (
    input  wire                         clk,
    input  wire                         arst_n,
    input  wire                         rx_line,
    input  wire                         cmd_start,
    output logic                        cmd_ready,
    input  wire uart_rx_pkg::bus_addr_t addr,
    output uart_rx_pkg::word_t          rdata,
    output logic                        rdata_valid
);

    // byte strobe between receiver and buffer
    uart_rx_pkg::byte_t rx_byte;
    logic               rx_valid;

    uart_rx_serial u_serial (
        .clk      (clk),
        .arst_n   (arst_n),
        .rx_line  (rx_line),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid)
    );

    uart_rx_mmio u_mmio (
        .clk         (clk),
        .arst_n      (arst_n),
        .rx_byte     (rx_byte),
        .rx_valid    (rx_valid),
        .cmd_start   (cmd_start),
        .cmd_ready   (cmd_ready),
        .addr        (addr),
        .rdata       (rdata),
        .rdata_valid (rdata_valid)
    );

endmodule

`default_nettype wire
